//--- Bender.yml
package:
  name: spi_cmd_master

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/spi_cmd_pkg.sv
      - design/spi_shift_if.sv
      - design/spi_sclk_gen.sv
      - design/spi_shifter.sv
      - design/spi_cmd_fsm.sv
      - design/spi_cmd_master.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/spi_cmd_properties.sv
      - tb/tb_clk_gen.sv
      - tb/spi_cmd_checker.sv
      - tb/tb_spi_cmd_master.sv

//--- design/spi_cmd_fsm.sv
`timescale 1ns/1ps
`include "spi_cmd_macros.svh"

module spi_cmd_fsm
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  spi_cmd_t  cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  output logic      cs,
  output logic      read_vld,
  output spi_data_t read_data,
  spi_shift_if.seq  sh
);

  localparam int          TURN_W   = $clog2(`SPI_TURN_CYC);
  localparam spi_bitcnt_t WR_BITS  = spi_bitcnt_t'(`SPI_CMD_W);
  localparam spi_bitcnt_t HDR_BITS = spi_bitcnt_t'(`SPI_RD_HDR_W);
  localparam spi_bitcnt_t RD_BITS  = spi_bitcnt_t'(`SPI_DATA_W);

  spi_seq_state_e    state;
  spi_seq_state_e    state_nxt;
  logic [TURN_W-1:0] turn_cnt;
  logic              accept;
  logic              turn_end;
  logic              is_write;

  assign cmd_rdy  = (state == IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign is_write = cmd_in[`SPI_CMD_W-1];  // Direction flag
  assign turn_end = (state == TURN) && !sh.busy &&
                    (turn_cnt == TURN_W'(`SPI_TURN_CYC - 1));

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (accept)
        begin
          state_nxt = is_write ? WRITE : READ_HDR;
        end
      end
      WRITE:
      begin
        if (sh.done)
        begin
          state_nxt = FINISH;
        end
      end
      READ_HDR:
      begin
        if (sh.done)
        begin
          state_nxt = TURN;
        end
      end
      TURN:
      begin
        if (turn_end)
        begin
          state_nxt = READ_DATA;
        end
      end
      READ_DATA:
      begin
        if (sh.done)
        begin
          state_nxt = FINISH;
        end
      end
      FINISH:    state_nxt = IDLE;  // cs already high
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      cs        <= 1'b1;
      sh.load   <= 1'b0;
      turn_cnt  <= '0;
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      state    <= state_nxt;
      // cs follows the next state so it moves one cycle after the event
      cs       <= (state_nxt == IDLE) || (state_nxt == FINISH);
      sh.load  <= accept || turn_end;
      read_vld <= (state == READ_DATA) && sh.done;
      if (state == TURN)
      begin
        turn_cnt <= turn_cnt + 1'b1;
      end
      else
      begin
        turn_cnt <= '0;
      end
      if ((state == READ_DATA) && sh.done)
      begin
        read_data <= sh.rx_byte;  // Held until next read
      end
    end
  end

  // Transfer setup for the shifter
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (is_write)
      begin
        sh.tx_word <= cmd_in;
        sh.nbits   <= WR_BITS;
      end
      else
      begin
        sh.tx_word <= {cmd_in[`SPI_CMD_W-1 -: `SPI_RD_HDR_W],
                       {(`SPI_CMD_W - `SPI_RD_HDR_W){1'b0}}};
        sh.nbits   <= HDR_BITS;
      end
    end
    else if (turn_end)
    begin
      sh.tx_word <= '0;  // mosi low while receiving
      sh.nbits   <= RD_BITS;
    end
  end

endmodule

//--- design/spi_cmd_macros.svh
`ifndef SPI_CMD_MACROS_SVH
`define SPI_CMD_MACROS_SVH

// Command word layout
`define SPI_CMD_W      12   // Full command width, direction bit on top
`define SPI_DATA_W     8    // Write and read data byte width
`define SPI_RD_HDR_W   4    // Direction flag plus address bits

// Bus timing in clk cycles
`define SPI_SCLK_HALF  4    // Cycles per sclk half period
`define SPI_TURN_CYC   100  // Idle cycles between read header and data

// Shifter bit counter, must hold SPI_CMD_W
`define SPI_CNT_W      4    // Bit counter width

`endif

//--- design/spi_cmd_master.sv
`timescale 1ns/1ps

module spi_cmd_master
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  spi_cmd_t  cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  output logic      sclk,
  output logic      cs,
  output logic      mosi,
  input  logic      miso,
  output logic      read_vld,
  output spi_data_t read_data
);

  logic sclk_en;
  logic sclk_rise;
  logic sclk_fall;

  spi_shift_if shift_bus ();

  spi_cmd_fsm i_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .read_vld  (read_vld),
    .read_data (read_data),
    .sh        (shift_bus.seq)
  );

  spi_shifter i_shifter (
    .clk     (clk),
    .rst_n   (rst_n),
    .miso    (miso),
    .rise    (sclk_rise),
    .fall    (sclk_fall),
    .mosi    (mosi),
    .sclk_en (sclk_en),
    .sh      (shift_bus.shift)
  );

  spi_sclk_gen i_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (sclk_en),
    .sclk  (sclk),
    .rise  (sclk_rise),
    .fall  (sclk_fall)
  );

endmodule

//--- design/spi_cmd_pkg.sv
`include "spi_cmd_macros.svh"

package spi_cmd_pkg;

  typedef logic [`SPI_CMD_W-1:0]                 spi_cmd_t;     // Dir, addr, data
  typedef logic [`SPI_CMD_W-`SPI_DATA_W-2:0]     spi_addr_t;    // Register address
  typedef logic [`SPI_DATA_W-1:0]                spi_data_t;    // Data byte
  typedef logic [`SPI_CNT_W-1:0]                 spi_bitcnt_t;  // Bits per transfer

  // Command sequencer states
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ_HDR,
    TURN,
    READ_DATA,
    FINISH
  } spi_seq_state_e;

endpackage

//--- design/spi_sclk_gen.sv
`timescale 1ns/1ps
`include "spi_cmd_macros.svh"

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic sclk,
  output logic rise,
  output logic fall
);

  localparam int HALF_W = $clog2(`SPI_SCLK_HALF);

  logic [HALF_W-1:0] half_cnt;
  logic              sclk_q;
  logic              half_end;

  assign half_end = en && (half_cnt == HALF_W'(`SPI_SCLK_HALF - 1));

  // Counter idles at zero so every transfer starts with a full low half
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk_q   <= 1'b0;
    end
    else if (!en)
    begin
      half_cnt <= '0;
      sclk_q   <= 1'b0;
    end
    else if (half_end)
    begin
      half_cnt <= '0;
      sclk_q   <= ~sclk_q;  // Edge at terminal count
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Strobes announce the edge taken at the end of this cycle
  assign rise = half_end && !sclk_q;
  assign fall = half_end && sclk_q;
  assign sclk = sclk_q;

endmodule

//--- design/spi_shift_if.sv
`timescale 1ns/1ps

interface spi_shift_if
  import spi_cmd_pkg::*;
();

  logic        load;     // One-cycle start strobe
  spi_cmd_t    tx_word;  // Left-aligned transmit word
  spi_bitcnt_t nbits;    // Bits to move this transfer
  logic        busy;     // Transfer in progress
  logic        done;     // Pulse after last bit
  spi_data_t   rx_byte;  // Valid with done

  // Command sequencer side
  modport seq (
    output load,
    output tx_word,
    output nbits,
    input  busy,
    input  done,
    input  rx_byte
  );

  // Shift register side
  modport shift (
    input  load,
    input  tx_word,
    input  nbits,
    output busy,
    output done,
    output rx_byte
  );

endinterface

//--- design/spi_shifter.sv
`timescale 1ns/1ps
`include "spi_cmd_macros.svh"

module spi_shifter
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      miso,
  input  logic      rise,
  input  logic      fall,
  output logic      mosi,
  output logic      sclk_en,
  spi_shift_if.shift sh
);

  spi_cmd_t    tx_q;      // MSB is on the bus
  spi_bitcnt_t bit_cnt;   // Bits still to finish
  spi_data_t   rx_q;
  logic        busy_q;
  logic        done_q;
  logic        last_bit;

  assign last_bit = (bit_cnt == spi_bitcnt_t'(1));

  // Transfer control and transmit path
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q    <= '0;
      bit_cnt <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (sh.load)
      begin
        tx_q    <= sh.tx_word;
        bit_cnt <= sh.nbits;
        busy_q  <= 1'b1;
      end
      else if (busy_q && fall)
      begin
        bit_cnt <= bit_cnt - 1'b1;
        if (last_bit)
        begin
          tx_q   <= '0;  // Leaves mosi low between frames
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
        else
        begin
          tx_q <= {tx_q[`SPI_CMD_W-2:0], 1'b0};
        end
      end
    end
  end

  // Receive path, sampled while sclk goes high
  always_ff @(posedge clk)
  begin
    if (busy_q && rise)
    begin
      rx_q <= {rx_q[$bits(spi_data_t)-2:0], miso};
    end
  end

  assign mosi       = tx_q[`SPI_CMD_W-1];
  assign sclk_en    = busy_q;
  assign sh.busy    = busy_q;
  assign sh.done    = done_q;
  assign sh.rx_byte = rx_q;

endmodule

//--- spi_cmd_master.f
+incdir+design
design/spi_cmd_pkg.sv
design/spi_shift_if.sv
design/spi_sclk_gen.sv
design/spi_shifter.sv
design/spi_cmd_fsm.sv
design/spi_cmd_master.sv
tb/spi_cmd_properties.sv
tb/tb_clk_gen.sv
tb/spi_cmd_checker.sv
tb/tb_spi_cmd_master.sv

//--- tb/spi_cmd_checker.sv
`timescale 1ns/1ps
`include "spi_cmd_macros.svh"

module spi_cmd_checker
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cs,
  input  logic      sclk,
  input  logic      mosi,
  input  logic      cmd_rdy,
  input  logic      read_vld,
  input  spi_data_t read_data,
  output int        tests_done,
  output int        err_cnt,
  output int        windows
);

  spi_cmd_t  exp_cmd_q[$];
  int        exp_len_q[$];  // Bits the master sends before any receive
  spi_data_t exp_rd_q[$];

  spi_cmd_t  frame;
  spi_cmd_t  cur_cmd;
  spi_data_t rd_exp;
  int        rise_n;
  int        fall_cyc;
  int        hdr_gap;
  int        cyc;
  int        err_mark;
  logic      rd_wait;
  logic      reset_seen;

  initial
  begin
    tests_done = 0;
    err_cnt    = 0;
    windows    = 0;
    cyc        = 0;
    rise_n     = 0;
    err_mark   = 0;
    rd_wait    = 1'b0;
    reset_seen = 1'b0;
  end

  task automatic expect_cmd(input spi_cmd_t cmd, input int len, input spi_data_t rd);
    exp_cmd_q.push_back(cmd);
    exp_len_q.push_back(len);
    exp_rd_q.push_back(rd);
  endtask

  task automatic finish_test(input string kind);
    tests_done++;
    $display("entry %0d %s cmd 0x%h: %s", tests_done, kind, cur_cmd,
             (err_cnt == err_mark) ? "ok" : "mismatch");
  endtask

  always @(negedge cs)
  begin
    if (rst_n === 1'b1)
    begin
      if (rd_wait)
      begin
        $display("No read_vld pulse seen for the read before time %0t", $time);
        err_cnt++;
        rd_wait = 1'b0;
      end
      windows++;
      rise_n   = 0;
      frame    = '0;
      hdr_gap  = 0;
      fall_cyc = cyc;
      err_mark = err_cnt;
    end
  end

  always @(posedge sclk)
  begin
    if (cs === 1'b0)
    begin
      if (rise_n == `SPI_RD_HDR_W)
      begin
        hdr_gap = cyc - fall_cyc;  // Idle span after the header
      end
      frame = {frame[`SPI_CMD_W-2:0], mosi};
      rise_n++;
    end
  end

  always @(negedge sclk)
  begin
    if (cs === 1'b0)
    begin
      fall_cyc = cyc;
    end
  end

  always @(posedge cs)
  begin : frame_end
    spi_cmd_t want;
    int       len;
    int       want_rises;
    if (rst_n === 1'b1)
    begin
      if (exp_cmd_q.size() == 0)
      begin
        $display("A cs-low window at time %0t had no command pending", $time);
        err_cnt++;
      end
      else
      begin
        cur_cmd    = exp_cmd_q.pop_front();
        len        = exp_len_q.pop_front();
        rd_exp     = exp_rd_q.pop_front();
        want       = cur_cmd & ~(spi_cmd_t'('1) >> len);  // Sent bits, zeros after
        want_rises = cur_cmd[`SPI_CMD_W-1] ? len : len + `SPI_DATA_W;
        if (rise_n != want_rises)
        begin
          $display("** Error at %0t: %0d sclk edges in frame, expected %0d",
                   $time, rise_n, want_rises);
          err_cnt++;
        end
        else if (frame !== want)
        begin
          $display("** Error at %0t: mosi frame 0x%h, expected 0x%h", $time, frame, want);
          err_cnt++;
        end
        if (!cur_cmd[`SPI_CMD_W-1] && (hdr_gap < `SPI_TURN_CYC))
        begin
          $display("** Error at %0t: turnaround %0d cycles, expected at least %0d",
                   $time, hdr_gap, `SPI_TURN_CYC);
          err_cnt++;
        end
        if (cur_cmd[`SPI_CMD_W-1])
        begin
          finish_test("write");
        end
        else
        begin
          rd_wait = 1'b1;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cyc++;
    if ((rst_n === 1'b1) && !reset_seen)
    begin
      reset_seen = 1'b1;
      if ((cs !== 1'b1) || (sclk !== 1'b0) || (mosi !== 1'b0) ||
          (read_vld !== 1'b0) || (cmd_rdy !== 1'b1))
      begin
        $display("** Error at %0t: outputs not in reset state", $time);
        err_cnt++;
      end
      $display("reset state checked");
    end
    if ((rst_n === 1'b1) && (read_vld === 1'b1))
    begin
      if (!rd_wait)
      begin
        $display("A read_vld pulse at time %0t had no read outstanding", $time);
        err_cnt++;
      end
      else
      begin
        if (read_data !== rd_exp)
        begin
          $display("** Error at %0t: read_data 0x%h, expected 0x%h", $time, read_data, rd_exp);
          err_cnt++;
        end
        rd_wait = 1'b0;
        finish_test("read");
      end
    end
  end

endmodule

//--- tb/spi_cmd_properties.sv
`timescale 1ns/1ps

module spi_cmd_properties (
  input logic clk,
  input logic rst_n,
  input logic cs,
  input logic sclk,
  input logic cmd_rdy,
  input logic read_vld
);

  int fail_cnt = 0;  // Failed assertion count

  // Bus clock stays parked outside a frame
  sclk_parked: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else
    begin
      $error("sclk high while cs is high");
      fail_cnt++;
    end

  // Ready only while the bus is idle
  rdy_idle: assert property (@(posedge clk) disable iff (!rst_n) !(cmd_rdy && !cs))
    else
    begin
      $error("cmd_rdy high during an active frame");
      fail_cnt++;
    end

  read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
    else
    begin
      $error("read_vld held longer than one cycle");
      fail_cnt++;
    end

endmodule

bind spi_cmd_master spi_cmd_properties i_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .cs       (cs),
  .sclk     (sclk),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int PERIOD_NS   = 100;
  localparam int RESET_CYCLES = 4;

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;  // Release just after an edge
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- tb/tb_spi_cmd_master.sv
`timescale 1ns/1ps
`include "spi_cmd_macros.svh"

module tb_spi_cmd_master
  import spi_cmd_pkg::*;
();

  localparam int N_FIXED = 9;
  localparam int N_RAND  = 8;
  localparam int N_ENT   = N_FIXED + N_RAND;
  localparam int BIT_CYC = 2 * `SPI_SCLK_HALF;
  localparam int TIMEOUT_CYC = N_ENT * (`SPI_CMD_W * BIT_CYC + `SPI_TURN_CYC +
                                        `SPI_DATA_W * BIT_CYC + 20);

  logic      clk;
  logic      rst_n;
  spi_cmd_t  cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      sclk;
  logic      cs;
  logic      mosi;
  logic      miso;
  logic      read_vld;
  spi_data_t read_data;
  int        tests_done;
  int        err_cnt;
  int        windows;

  spi_cmd_t  tbl_cmd [N_ENT];
  int        tbl_len [N_ENT];
  spi_data_t tbl_rd  [N_ENT];
  int        tbl_gap [N_ENT];
  spi_data_t model_regs [8];  // Expected register contents
  int        n_ent;
  integer    seed;
  int        cyc_cnt;

  spi_data_t slave_regs [8];
  spi_cmd_t  slave_sr;
  spi_data_t slave_out;
  int        slave_bits = 0;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spi_cmd_master i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_cmd_checker i_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cs         (cs),
    .sclk       (sclk),
    .mosi       (mosi),
    .cmd_rdy    (cmd_rdy),
    .read_vld   (read_vld),
    .read_data  (read_data),
    .tests_done (tests_done),
    .err_cnt    (err_cnt),
    .windows    (windows)
  );

  // SPI slave register model
  always @(negedge cs) slave_bits = 0;

  always @(posedge sclk)
  begin
    if (cs === 1'b0)
    begin
      slave_sr = {slave_sr[`SPI_CMD_W-2:0], mosi};
      slave_bits++;
    end
  end

  always @(negedge sclk)
  begin
    if (cs === 1'b0)
    begin
      if ((slave_bits == `SPI_RD_HDR_W) && !slave_sr[`SPI_RD_HDR_W-1])
      begin
        slave_out = slave_regs[slave_sr[2:0]];  // Read header complete
      end
      else
      begin
        slave_out = {slave_out[`SPI_DATA_W-2:0], 1'b0};
      end
      miso = slave_out[`SPI_DATA_W-1];
    end
  end

  always @(posedge cs)
  begin
    if ((slave_bits == `SPI_CMD_W) && slave_sr[`SPI_CMD_W-1])
    begin
      slave_regs[slave_sr[10:8]] = slave_sr[7:0];
    end
  end

  task automatic add_entry(input logic dir, input spi_addr_t addr, input spi_data_t data,
                           input int gap);
    tbl_cmd[n_ent] = {dir, addr, data};
    tbl_len[n_ent] = dir ? `SPI_CMD_W : `SPI_RD_HDR_W;
    tbl_rd[n_ent]  = dir ? '0 : model_regs[addr];
    tbl_gap[n_ent] = gap;
    if (dir)
    begin
      model_regs[addr] = data;
    end
    n_ent++;
  endtask

  initial
  begin : stimulus
    integer r;
    int     i;
    int     assert_fails;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    miso    = 1'b0;
    seed    = 96699;
    n_ent   = 0;
    for (i = 0; i < 8; i++)
    begin
      model_regs[i] = '0;
      slave_regs[i] = '0;
    end
    add_entry(1'b0, 3'd2, 8'h00, 3);  // Never written
    add_entry(1'b1, 3'd2, 8'ha5, 2);
    add_entry(1'b0, 3'd2, 8'h00, 0);
    add_entry(1'b1, 3'd7, 8'h3c, 1);
    add_entry(1'b1, 3'd0, 8'hff, 0);
    add_entry(1'b0, 3'd7, 8'h00, 4);
    add_entry(1'b0, 3'd0, 8'h00, 2);
    add_entry(1'b1, 3'd2, 8'h5a, 0);  // Overwrite
    add_entry(1'b0, 3'd2, 8'h00, 1);
    for (i = 0; i < N_RAND; i++)
    begin
      r = $random(seed);
      add_entry(r[11], r[10:8], r[7:0], r[14:12]);
    end

    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    for (i = 0; i < n_ent; i++)
    begin
      i_chk.expect_cmd(tbl_cmd[i], tbl_len[i], tbl_rd[i]);
      cmd_in  = tbl_cmd[i];
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      while (!cmd_rdy)  // Valid stays high while busy
      begin
        @(posedge clk);
        #1;
      end
      cmd_vld = 1'b0;
      repeat (tbl_gap[i])
      begin
        @(posedge clk);
        #1;
      end
    end

    repeat (4) @(posedge clk);
    assert_fails = i_dut.i_props.fail_cnt;
    if (windows != n_ent)
    begin
      $display("Saw %0d cs-low windows for %0d commands", windows, n_ent);
    end
    if (tests_done != n_ent)
    begin
      $display("Only %0d of %0d entries completed", tests_done, n_ent);
    end
    if (assert_fails != 0)
    begin
      $display("Bus protocol assertions failed %0d times", assert_fails);
    end
    $display("Summary: %0d entries, %0d completed, %0d errors", n_ent, tests_done,
             err_cnt + assert_fails);
    if ((err_cnt == 0) && (assert_fails == 0) && (windows == n_ent) &&
        (tests_done == n_ent))
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    cyc_cnt = 0;
    while (cyc_cnt < TIMEOUT_CYC)
    begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
    $display("Test failed");
    $finish;
  end

endmodule
